// File: hw/soc_cfg.svh
// SoC bus slice configuration: widths, address windows, RAM depth and vectors
`ifndef SOC_CFG_SVH
`define SOC_CFG_SVH

// Wishbone data and address widths
`define SOC_DW        16
`define SOC_AW        19  // Word address, the io tag sits above it
`define SOC_SELW      2   // One select bit per byte lane

// Interrupt lines into the PIC
`define SOC_NIRQ      8

// Words returned to the processor during acknowledge cycles
`define SOC_IRQ_BASE  16'h0008  // Vector of irq 0
`define SOC_NMI_VEC   16'h0002

// Base RAM index bits, 256 words
`define SOC_RAM_AW    8

// GPIO window, byte ports 0xF100 to 0xF103 as port words
`define SOC_GPIO_PORT 15'h7880
`define SOC_GPIO_MASK 15'h7ffe  // Bit 0 picks the register

// Board I/O
`define SOC_NLED      14  // 10 red plus 4 green
`define SOC_NSW       10
`define SOC_NKEY      4   // Push-buttons, active low

`endif

// File: hw/soc_pkg.sv
// Shared bus types: tagged address, Wishbone request and response, slave select
`default_nettype none

`include "soc_cfg.svh"

package soc_pkg;

  // Memory space view of the tagged address
  typedef struct packed {
    logic               io;   // 0 for memory space
    logic [`SOC_AW-1:0] adr;  // Word address
  } mem_addr_t;

  // I/O space view, the port word is the byte port divided by two
  typedef struct packed {
    logic        io;    // 1 for I/O space
    logic [3:0]  pad;   // Not decoded for I/O
    logic [14:0] port;
  } io_addr_t;

  // Same 20-bit bus address, read either way
  typedef union packed {
    mem_addr_t mem;
    io_addr_t  io;
  } bus_addr_u;

  // Master to slave
  typedef struct packed {
    bus_addr_u            adr;
    logic [`SOC_DW-1:0]   dat;
    logic [`SOC_SELW-1:0] sel;
    logic                 we;
    logic                 cyc;
    logic                 stb;
  } wb_req_t;

  // Slave to master
  typedef struct packed {
    logic [`SOC_DW-1:0] dat;
    logic               ack;
  } wb_rsp_t;

  // Target of the current access
  typedef enum logic [1:0] {
    SLV_RAM,
    SLV_GPIO,
    SLV_DEF
  } slave_sel_t;

endpackage

`default_nettype wire

// File: hw/wb_switch.sv
// Wishbone address decoder and router, with the default slave for unmapped I/O
`default_nettype none

`include "soc_cfg.svh"

module wb_switch
  import soc_pkg::*;
(
  // Master side
  input  wb_req_t m_req_i,
  output wb_rsp_t m_rsp_o,

  // Base RAM
  output wb_req_t ram_req_o,
  input  wb_rsp_t ram_rsp_i,

  // GPIO block
  output wb_req_t gpio_req_o,
  input  wb_rsp_t gpio_rsp_i
);

  slave_sel_t slv;
  logic       gpio_hit;
  logic       req_vld;
  wb_rsp_t    def_rsp;

  // GPIO window compare on the port word
  assign gpio_hit = (m_req_i.adr.io.port & `SOC_GPIO_MASK) == `SOC_GPIO_PORT;

  // Memory space is all RAM, I/O splits between GPIO and default
  always_comb begin
    if (!m_req_i.adr.mem.io) begin
      slv = SLV_RAM;
    end else if (gpio_hit) begin
      slv = SLV_GPIO;
    end else begin
      slv = SLV_DEF;
    end
  end

  assign req_vld = m_req_i.cyc & m_req_i.stb;

  // Request fan-out, only the selected slave sees cyc and stb
  always_comb begin
    ram_req_o      = m_req_i;
    ram_req_o.cyc  = m_req_i.cyc & (slv == SLV_RAM);
    ram_req_o.stb  = m_req_i.stb & (slv == SLV_RAM);

    gpio_req_o     = m_req_i;
    gpio_req_o.cyc = m_req_i.cyc & (slv == SLV_GPIO);
    gpio_req_o.stb = m_req_i.stb & (slv == SLV_GPIO);
  end

  // Default slave
  // Zero data, acked in the same cycle so the master never stalls
  always_comb begin
    def_rsp.dat = '0;
    def_rsp.ack = req_vld & (slv == SLV_DEF);
  end

  // Response return path
  always_comb begin
    case (slv)
      SLV_RAM:  m_rsp_o = ram_rsp_i;
      SLV_GPIO: m_rsp_o = gpio_rsp_i;
      default:  m_rsp_o = def_rsp;   // Also the unused encoding
    endcase
  end

endmodule

`default_nettype wire

// File: hw/base_ram.sv
// Base RAM slave, byte-lane writes and registered read data and ack
`default_nettype none

`include "soc_cfg.svh"

module base_ram
  import soc_pkg::*;
(
  input  logic    clk,
  input  logic    rst_lck,
  input  wb_req_t req_i,
  output wb_rsp_t rsp_o
);

  localparam int ram_depth = 1 << `SOC_RAM_AW;

  logic [`SOC_DW-1:0]     mem [ram_depth];
  logic [`SOC_RAM_AW-1:0] idx;
  logic [`SOC_DW-1:0]     rd_q;
  logic                   ack_q;
  logic                   xfer;

  // Low word-address bits only, so upper addresses alias
  assign idx  = req_i.adr.mem.adr[`SOC_RAM_AW-1:0];
  assign xfer = req_i.cyc & req_i.stb & ~ack_q;  // One ack per transfer

  // Storage and read port
  always_ff @(posedge clk) begin
    if (xfer && req_i.we) begin
      for (int i = 0; i < `SOC_SELW; i++) begin
        if (req_i.sel[i]) begin
          mem[idx][8*i +: 8] <= req_i.dat[8*i +: 8];
        end
      end
    end
    if (xfer) begin
      rd_q <= mem[idx];  // Old word, only meaningful for reads
    end
  end

  always_ff @(posedge clk) begin
    if (!rst_lck) begin
      ack_q <= 1'b0;
    end else begin
      ack_q <= xfer;
    end
  end

  assign rsp_o.dat = rd_q;
  assign rsp_o.ack = ack_q;

endmodule

`default_nettype wire

// File: hw/gpio_ports.sv
// GPIO slave: switch and push-button read, LED write, push-button NMI latch
`default_nettype none

`include "soc_cfg.svh"

module gpio_ports
  import soc_pkg::*;
(
  input  logic                 clk,
  input  logic                 rst_lck,
  input  wb_req_t              req_i,
  output wb_rsp_t              rsp_o,
  input  logic [`SOC_NSW-1:0]  sw_i,
  input  logic [`SOC_NKEY-1:0] key_i,   // Active low
  output logic [`SOC_NLED-1:0] leds_o,
  output logic                 nmi_o,
  input  logic                 nmia_i
);

  logic [`SOC_NLED-1:0] leds_q;
  logic [`SOC_DW-1:0]   lane_mask;
  logic [`SOC_DW-1:0]   led_next;
  logic [`SOC_DW-1:0]   rd_next;
  logic [`SOC_DW-1:0]   rd_q;
  logic                 ack_q;
  logic                 xfer;
  logic                 key_reg;   // Bit 1 selects the keys
  logic                 key_q;
  logic                 key_fall;
  logic                 nmi_q;

  assign xfer    = req_i.cyc & req_i.stb & ~ack_q;
  assign key_reg = req_i.adr.io.port[0];

  // Byte-lane merge into the LED register
  always_comb begin
    for (int i = 0; i < `SOC_SELW; i++) begin
      lane_mask[8*i +: 8] = {8{req_i.sel[i]}};
    end
  end

  assign led_next = ({{(`SOC_DW-`SOC_NLED){1'b0}}, leds_q} & ~lane_mask)
                  | (req_i.dat & lane_mask);

  // Read mux, keys shown pressed as 1
  assign rd_next = key_reg ? {{(`SOC_DW-`SOC_NKEY){1'b0}}, ~key_i}
                           : {{(`SOC_DW-`SOC_NSW){1'b0}}, sw_i};

  // Last push-button drives the NMI
  assign key_fall = key_q & ~key_i[`SOC_NKEY-1];

  always_ff @(posedge clk) begin
    if (xfer) begin
      rd_q <= rd_next;
    end
  end

  always_ff @(posedge clk) begin
    if (!rst_lck) begin
      ack_q  <= 1'b0;
      leds_q <= '0;
      key_q  <= 1'b1;   // Released
      nmi_q  <= 1'b0;
    end else begin
      ack_q <= xfer;
      if (xfer && req_i.we && !key_reg) begin
        leds_q <= led_next[`SOC_NLED-1:0];
      end
      key_q <= key_i[`SOC_NKEY-1];
      if (key_fall) begin
        nmi_q <= 1'b1;    // New press wins over acknowledge
      end else if (nmia_i) begin
        nmi_q <= 1'b0;
      end
    end
  end

  assign rsp_o.dat = rd_q;
  assign rsp_o.ack = ack_q;
  assign leds_o    = leds_q;
  assign nmi_o     = nmi_q;

endmodule

`default_nettype wire

// File: hw/simple_pic.sv
// Edge-triggered priority interrupt controller, lowest line wins
`default_nettype none

`include "soc_cfg.svh"

module simple_pic (
  input  logic                         clk,
  input  logic                         rst_lck,
  input  logic [`SOC_NIRQ-1:0]         irq_i,
  input  logic                         inta_i,
  output logic                         intr_o,
  output logic [$clog2(`SOC_NIRQ)-1:0] iid_o
);

  localparam int iw = $clog2(`SOC_NIRQ);

  logic [`SOC_NIRQ-1:0] irq_q;
  logic [`SOC_NIRQ-1:0] pend_q;
  logic [`SOC_NIRQ-1:0] irq_rise;
  logic [`SOC_NIRQ-1:0] clr_mask;
  logic [iw-1:0]        iid;
  logic                 inta_q;
  logic                 inta_rise;

  assign irq_rise  = irq_i & ~irq_q;
  assign inta_rise = inta_i & ~inta_q;

  // Priority encoder
  // Scan from the top so the lowest pending index is left in iid
  always_comb begin
    iid = '0;
    for (int i = `SOC_NIRQ - 1; i >= 0; i--) begin
      if (pend_q[i]) begin
        iid = i[iw-1:0];
      end
    end
  end

  // Acknowledge retires the line being served right now
  always_comb begin
    clr_mask = '0;
    if (inta_rise) begin
      clr_mask[iid] = 1'b1;
    end
  end

  always_ff @(posedge clk) begin
    if (!rst_lck) begin
      irq_q  <= '0;
      pend_q <= '0;
      inta_q <= 1'b0;
    end else begin
      irq_q  <= irq_i;
      inta_q <= inta_i;
      pend_q <= (pend_q & ~clr_mask) | irq_rise;  // Fresh edge beats clear
    end
  end

  assign intr_o = |pend_q;
  assign iid_o  = iid;

endmodule

`default_nettype wire

// File: hw/soc_core.sv
// SoC bus slice top: switch, RAM, GPIO and PIC, with the processor read merge
`default_nettype none

`include "soc_cfg.svh"

module soc_core
  import soc_pkg::*;
(
  input  logic                         clk,
  input  logic                         rst_lck,

  // Processor bus
  input  wb_req_t                      cpu_req_i,
  output wb_rsp_t                      cpu_rsp_o,

  // Interrupt handshake
  input  logic                         inta_i,
  input  logic                         nmia_i,
  output logic                         intr_o,
  output logic                         nmi_o,
  input  logic [`SOC_NIRQ-1:0]         irq_i,

  // Board I/O
  input  logic [`SOC_NSW-1:0]          sw_i,
  input  logic [`SOC_NKEY-1:0]         key_i,
  output logic [`SOC_NLED-1:0]         leds_o
);

  localparam int iw = $clog2(`SOC_NIRQ);

  wb_req_t            ram_req;
  wb_rsp_t            ram_rsp;
  wb_req_t            gpio_req;
  wb_rsp_t            gpio_rsp;
  wb_rsp_t            bus_rsp;
  logic [iw-1:0]      iid;
  logic [`SOC_DW-1:0] vec_word;

  wb_switch wb_switch_inst (
    .m_req_i    (cpu_req_i),
    .m_rsp_o    (bus_rsp),
    .ram_req_o  (ram_req),
    .ram_rsp_i  (ram_rsp),
    .gpio_req_o (gpio_req),
    .gpio_rsp_i (gpio_rsp)
  );

  base_ram base_ram_inst (
    .clk     (clk),
    .rst_lck (rst_lck),
    .req_i   (ram_req),
    .rsp_o   (ram_rsp)
  );

  gpio_ports gpio_ports_inst (
    .clk     (clk),
    .rst_lck (rst_lck),
    .req_i   (gpio_req),
    .rsp_o   (gpio_rsp),
    .sw_i    (sw_i),
    .key_i   (key_i),
    .leds_o  (leds_o),
    .nmi_o   (nmi_o),     // From the push-button
    .nmia_i  (nmia_i)
  );

  simple_pic simple_pic_inst (
    .clk     (clk),
    .rst_lck (rst_lck),
    .irq_i   (irq_i),
    .inta_i  (inta_i),
    .intr_o  (intr_o),
    .iid_o   (iid)
  );

  assign vec_word = `SOC_IRQ_BASE + {{(`SOC_DW-iw){1'b0}}, iid};

  // Read word to the processor
  // NMI acknowledge first, then interrupt vector, then plain bus data
  always_comb begin
    cpu_rsp_o.ack = bus_rsp.ack;  // Acknowledge cycles still end on the bus
    if (nmia_i) begin
      cpu_rsp_o.dat = `SOC_NMI_VEC;
    end else if (inta_i) begin
      cpu_rsp_o.dat = vec_word;
    end else begin
      cpu_rsp_o.dat = bus_rsp.dat;
    end
  end

endmodule

`default_nettype wire

// File: verification/soc_tb.sv
// Testbench for the SoC bus slice: table-driven bus, GPIO, PIC and NMI checks
`default_nettype none

`include "soc_cfg.svh"

module soc_tb
  import soc_pkg::*;
;
  timeunit 1ns;
  timeprecision 100ps;

  localparam int clk_period = 20;
  localparam int sample_ofs = 5;   // Quarter period after the falling edge
  localparam int ack_limit  = 8;

  typedef enum logic [2:0] {K_WR, K_RD, K_INTA, K_NMIA, K_IRQ, K_KEY, K_FLAG, K_LED} kind_t;

  typedef struct packed {
    kind_t       kind;
    logic        io;
    logic [18:0] adr;   // Word address, or byte port for I/O
    logic [15:0] dat;
    logic [1:0]  sel;
    logic [15:0] exp;   // Read word, {nmi, intr} or LEDs
  } step_t;

  logic                 clk = 1'b0;
  logic                 rst_lck;
  wb_req_t              cpu_req;
  wb_rsp_t              cpu_rsp;
  logic                 inta;
  logic                 nmia;
  logic                 intr_o;
  logic                 nmi_o;
  logic [`SOC_NIRQ-1:0] irq;
  logic [`SOC_NSW-1:0]  sw;
  logic [`SOC_NKEY-1:0] key;
  logic [`SOC_NLED-1:0] leds_o;

  step_t       steps[$];
  logic [15:0] ram_model [256];
  logic [15:0] lfsr_q;
  logic        table_built = 1'b0;
  int          err_cnt = 0;
  int          pass_cnt = 0;
  int          fail_cnt = 0;

  soc_core soc_core_inst (
    .clk       (clk),
    .rst_lck   (rst_lck),
    .cpu_req_i (cpu_req),
    .cpu_rsp_o (cpu_rsp),
    .inta_i    (inta),
    .nmia_i    (nmia),
    .intr_o    (intr_o),
    .nmi_o     (nmi_o),
    .irq_i     (irq),
    .sw_i      (sw),
    .key_i     (key),
    .leds_o    (leds_o)
  );

  always #(clk_period / 2) clk = ~clk;

  // Galois LFSR, x^16 + x^14 + x^13 + x^11 + 1
  function automatic logic [15:0] lfsr_next(input logic [15:0] s);
    return s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);
  endfunction

  function automatic logic [15:0] random_word(input int nbits);
    logic [15:0] v;
    v = '0;
    for (int i = 0; i < nbits; i++) begin
      lfsr_q = lfsr_next(lfsr_q);
      v = {v[14:0], lfsr_q[0]};  // One step per bit
    end
    return v;
  endfunction

  function automatic bus_addr_u bus_addr(input logic io, input logic [18:0] a);
    bus_addr_u u;
    if (io) begin
      u.io.io   = 1'b1;
      u.io.pad  = 4'h0;
      u.io.port = a[15:1];   // Byte port to port word
    end else begin
      u.mem.io  = 1'b0;
      u.mem.adr = a;
    end
    return u;
  endfunction

  function automatic void add_step(input kind_t k, input logic io, input logic [18:0] a,
                                   input logic [15:0] d, input logic [1:0] s,
                                   input logic [15:0] e);
    step_t st;
    st.kind = k;
    st.io   = io;
    st.adr  = a;
    st.dat  = d;
    st.sel  = s;
    st.exp  = e;
    steps.push_back(st);
  endfunction

  function automatic void ram_write(input logic [18:0] a, input logic [1:0] s);
    logic [15:0] d;
    d = random_word(16);
    for (int i = 0; i < 2; i++) begin
      if (s[i]) begin
        ram_model[a[7:0]][8*i +: 8] = d[8*i +: 8];  // 256 words, upper bits alias
      end
    end
    add_step(K_WR, 1'b0, a, d, s, 16'h0000);
  endfunction

  function automatic void ram_read(input logic [18:0] a);
    add_step(K_RD, 1'b0, a, 16'h0000, 2'b11, ram_model[a[7:0]]);
  endfunction

  function automatic void build_table();
    logic [18:0] a [6];
    logic [15:0] w;
    // Reset state
    add_step(K_LED, 1'b0, 19'h0, 16'h0000, 2'b00, 16'h0000);
    add_step(K_FLAG, 1'b0, 19'h0, 16'h0000, 2'b00, 16'h0000);
    // RAM at random addresses
    for (int i = 0; i < 6; i++) begin
      w = random_word(8);
      a[i] = {11'h000, w[7:0]};
      ram_write(a[i], 2'b11);
    end
    ram_write(a[0], 2'b01);
    ram_write(a[1], 2'b10);
    for (int i = 0; i < 6; i++) begin
      ram_read(a[i]);
    end
    ram_read({11'h001, a[0][7:0]});   // 256 words higher
    ram_read({11'h7ff, a[1][7:0]});
    // GPIO switches, LEDs by lane, keys
    add_step(K_RD, 1'b1, 19'h0F100, 16'h0000, 2'b11, 16'h02A5);
    add_step(K_WR, 1'b1, 19'h0F100, 16'h3FFF, 2'b11, 16'h0000);
    add_step(K_LED, 1'b0, 19'h0, 16'h0000, 2'b00, 16'h3FFF);
    add_step(K_WR, 1'b1, 19'h0F100, 16'hAA55, 2'b01, 16'h0000);
    add_step(K_LED, 1'b0, 19'h0, 16'h0000, 2'b00, 16'h3F55);
    add_step(K_WR, 1'b1, 19'h0F100, 16'h1277, 2'b10, 16'h0000);
    add_step(K_LED, 1'b0, 19'h0, 16'h0000, 2'b00, 16'h1255);
    add_step(K_WR, 1'b1, 19'h0F102, 16'hFFFF, 2'b11, 16'h0000);  // Key port, ignored
    add_step(K_LED, 1'b0, 19'h0, 16'h0000, 2'b00, 16'h1255);
    add_step(K_KEY, 1'b0, 19'h0, 16'h000E, 2'b00, 16'h0000);
    add_step(K_RD, 1'b1, 19'h0F102, 16'h0000, 2'b11, 16'h0001);
    add_step(K_KEY, 1'b0, 19'h0, 16'h000F, 2'b00, 16'h0000);
    // Default slave, port 0x0300 would alias RAM word 0x80
    ram_write(19'h00080, 2'b11);
    add_step(K_RD, 1'b1, 19'h00300, 16'h0000, 2'b11, 16'h0000);
    add_step(K_WR, 1'b1, 19'h00300, 16'hFFFF, 2'b11, 16'h0000);
    ram_read(19'h00080);
    add_step(K_LED, 1'b0, 19'h0, 16'h0000, 2'b00, 16'h1255);
    // PIC, vectors 8 + 2 then 8 + 5
    add_step(K_IRQ, 1'b0, 19'h0, 16'h0024, 2'b00, 16'h0001);
    add_step(K_INTA, 1'b1, 19'h00300, 16'h0000, 2'b11, 16'd10);
    add_step(K_FLAG, 1'b0, 19'h0, 16'h0000, 2'b00, 16'h0001);
    add_step(K_INTA, 1'b1, 19'h00300, 16'h0000, 2'b11, 16'd13);
    add_step(K_FLAG, 1'b0, 19'h0, 16'h0000, 2'b00, 16'h0000);
    // NMI over a pending irq 1
    add_step(K_IRQ, 1'b0, 19'h0, 16'h0000, 2'b00, 16'h0000);
    add_step(K_IRQ, 1'b0, 19'h0, 16'h0002, 2'b00, 16'h0001);
    add_step(K_KEY, 1'b0, 19'h0, 16'h0007, 2'b00, 16'h0003);
    add_step(K_NMIA, 1'b1, 19'h00300, 16'h0000, 2'b11, 16'h0002);
    add_step(K_FLAG, 1'b0, 19'h0, 16'h0000, 2'b00, 16'h0001);
    add_step(K_INTA, 1'b1, 19'h00300, 16'h0000, 2'b11, 16'd9);
    add_step(K_FLAG, 1'b0, 19'h0, 16'h0000, 2'b00, 16'h0000);
    add_step(K_KEY, 1'b0, 19'h0, 16'h000F, 2'b00, 16'h0000);
  endfunction

  // One Wishbone classic transfer, sampled a quarter period after each falling edge
  task automatic bus_xfer(input step_t st, output logic [15:0] rdata, output logic acked);
    int n;
    @(negedge clk);
    cpu_req.adr = bus_addr(st.io, st.adr);
    cpu_req.dat = st.dat;
    cpu_req.sel = st.sel;
    cpu_req.we  = (st.kind == K_WR);
    cpu_req.cyc = 1'b1;
    cpu_req.stb = 1'b1;
    inta        = (st.kind == K_INTA);
    nmia        = (st.kind == K_NMIA);
    acked = 1'b0;
    rdata = '0;
    n = 0;
    while (!acked && n < ack_limit) begin
      #(sample_ofs);
      if (cpu_rsp.ack) begin
        acked = 1'b1;
        rdata = cpu_rsp.dat;
      end
      @(negedge clk);
      n++;
    end
    cpu_req.cyc = 1'b0;
    cpu_req.stb = 1'b0;
    cpu_req.we  = 1'b0;
    inta        = 1'b0;
    nmia        = 1'b0;
  endtask

  task automatic run_step(input int num, input step_t st);
    logic [15:0] got;
    logic        acked;
    int          errs_before;
    errs_before = err_cnt;
    case (st.kind)
      K_WR, K_RD, K_INTA, K_NMIA: begin
        bus_xfer(st, got, acked);
        if (!acked) begin
          $display("Test %0d: the bus never acknowledged the transfer at %0t", num, $time);
          err_cnt++;
        end else if (st.kind != K_WR && got !== st.exp) begin
          $display("ERR %0t: test %0d %s returned %h, expected %h",
                   $time, num, st.kind.name(), got, st.exp);
          err_cnt++;
        end
      end
      K_IRQ, K_KEY, K_FLAG: begin
        @(negedge clk);
        if (st.kind == K_IRQ) begin
          irq = st.dat[7:0];
        end
        if (st.kind == K_KEY) begin
          key = st.dat[3:0];
        end
        repeat (2) @(negedge clk);  // Edges are seen within two clocks
        if ({nmi_o, intr_o} !== st.exp[1:0]) begin
          $display("ERR %0t: test %0d %s gave nmi/intr %b, expected %b",
                   $time, num, st.kind.name(), {nmi_o, intr_o}, st.exp[1:0]);
          err_cnt++;
        end
      end
      default: begin
        if (leds_o !== st.exp[13:0]) begin
          $display("ERR %0t: test %0d LEDs %h, expected %h", $time, num, leds_o, st.exp[13:0]);
          err_cnt++;
        end
      end
    endcase
    if (err_cnt == errs_before) begin
      pass_cnt++;
    end else begin
      fail_cnt++;
    end
    $display("Test %0d %s %s", num, st.kind.name(), (err_cnt == errs_before) ? "ok" : "bad");
  endtask

  initial begin
    rst_lck = 1'b0;
    cpu_req = '0;
    inta    = 1'b0;
    nmia    = 1'b0;
    irq     = '0;
    sw      = 10'h2A5;
    key     = 4'hF;   // All released
    lfsr_q  = 16'd39618;
    build_table();
    table_built = 1'b1;
    repeat (16) @(posedge clk);
    @(negedge clk);
    rst_lck = 1'b1;
    for (int t = 0; t < steps.size(); t++) begin
      run_step(t, steps[t]);
    end
    $display("Done: %0d tests, %0d passed, %0d failed, %0d errors",
             pass_cnt + fail_cnt, pass_cnt, fail_cnt, err_cnt);
    if (err_cnt == 0) begin
      $display("TEST OK");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

  // Watchdog, 50 clocks per table entry plus reset
  initial begin
    wait (table_built);
    #((steps.size() * 50 + 20) * clk_period);
    $display("Watchdog expired, the test sequence did not finish in time");
    $display("TEST FAILED");
    $finish;
  end

endmodule

`default_nettype wire

// File: flist.f
+incdir+hw
hw/soc_pkg.sv
hw/wb_switch.sv
hw/base_ram.sv
hw/gpio_ports.sv
hw/simple_pic.sv
hw/soc_core.sv
verification/soc_tb.sv

// File: Makefile
# Verilator build and run for the SoC bus slice
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing -j 0
TOP       ?= soc_tb
FLIST     ?= flist.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log

SOURCES := $(FLIST) $(wildcard hw/*.sv hw/*.svh verification/*.sv)

.PHONY: all compile run clean

all: run

compile: $(OBJ_DIR)/V$(TOP)

$(OBJ_DIR)/V$(TOP): $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FLIST)

# The log decides the result
run: compile
	-./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "TEST FAILED" $(LOG); then echo "Simulation reported failure"; exit 1; fi
	@grep -q "TEST OK" $(LOG) || (echo "No result line found in $(LOG)"; exit 1)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
